// File: execCluster.f
+incdir+sim
hw/execPkg.sv
hw/bundleDispatch.sv
hw/instDecode.sv
hw/execLane.sv
hw/resultCollect.sv
hw/execCluster.sv
sim/execClusterTb.sv

// File: hw/bundleDispatch.sv
module bundleDispatch #(
    parameter int Lanes = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               inStrobe,
    input  logic [Lanes-1:0]                   laneMask,
    input  logic [Lanes*execPkg::InstWidth-1:0] insts,
    input  logic [Lanes*execPkg::XLen-1:0]     rs1Vals,
    input  logic [Lanes*execPkg::XLen-1:0]     rs2Vals,
    input  logic [execPkg::XLen-1:0]           basePc,
    output logic [Lanes-1:0]                   laneValid,
    output logic [Lanes*execPkg::InstWidth-1:0] laneInst,
    output logic [Lanes*execPkg::XLen-1:0]     laneRs1,
    output logic [Lanes*execPkg::XLen-1:0]     laneRs2,
    output logic [Lanes*execPkg::XLen-1:0]     lanePc
);

    // valid bits live for one cycle only, they strobe the lanes
    always_ff @(posedge clk) begin
        if (reset) begin
            laneValid <= '0;
        end else begin
            laneValid <= inStrobe ? laneMask : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (inStrobe) begin
            laneInst <= insts;
            laneRs1  <= rs1Vals;
            laneRs2  <= rs2Vals;
            for (int i = 0; i < Lanes; i++) begin
                lanePc[i*execPkg::XLen +: execPkg::XLen] <= basePc + execPkg::XLen'(4 * i);
            end
        end
    end

endmodule

// File: hw/execCluster.sv
module execCluster #(
    parameter int Lanes = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                inStrobe,
    input  logic [Lanes-1:0]                    laneMask,
    input  logic [Lanes*execPkg::InstWidth-1:0] insts,
    input  logic [Lanes*execPkg::XLen-1:0]      rs1Vals,
    input  logic [Lanes*execPkg::XLen-1:0]      rs2Vals,
    input  logic [execPkg::XLen-1:0]            basePc,
    output logic                                outStrobe,
    output logic [Lanes-1:0]                    wbEnable,
    output logic [Lanes*execPkg::XLen-1:0]      wbData,
    output logic [Lanes-1:0]                    memReadEn,
    output logic [Lanes-1:0]                    memWriteEn,
    output logic [Lanes*execPkg::XLen-1:0]      memAddr,
    output logic                                redirect,
    output logic [execPkg::XLen-1:0]            redirectPc,
    output logic [Lanes-1:0]                    illegalMask
);

    localparam int W = execPkg::XLen;
    localparam int IW = execPkg::InstWidth;

    logic [Lanes-1:0]      laneValid;
    logic [Lanes*IW-1:0]   laneInst;
    logic [Lanes*W-1:0]    laneRs1, laneRs2, lanePc;
    logic [Lanes-1:0]      resValid, resWrite, resMemRead, resMemWrite, resTaken, resIllegal;
    logic [Lanes*W-1:0]    resData, resAddr, resTarget;

    bundleDispatch #(.Lanes(Lanes)) dispatch (
        .clk(clk), .reset(reset), .inStrobe(inStrobe), .laneMask(laneMask),
        .insts(insts), .rs1Vals(rs1Vals), .rs2Vals(rs2Vals), .basePc(basePc),
        .laneValid(laneValid), .laneInst(laneInst), .laneRs1(laneRs1),
        .laneRs2(laneRs2), .lanePc(lanePc)
    );

    for (genvar i = 0; i < Lanes; i++) begin : lane
        execLane exec (
            .clk(clk), .reset(reset), .laneValid(laneValid[i]),
            .inst(laneInst[i*IW +: IW]), .rs1(laneRs1[i*W +: W]),
            .rs2(laneRs2[i*W +: W]), .pc(lanePc[i*W +: W]),
            .resValid(resValid[i]), .resWrite(resWrite[i]), .resData(resData[i*W +: W]),
            .resMemRead(resMemRead[i]), .resMemWrite(resMemWrite[i]),
            .resAddr(resAddr[i*W +: W]), .resTaken(resTaken[i]),
            .resTarget(resTarget[i*W +: W]), .resIllegal(resIllegal[i])
        );
    end

    resultCollect #(.Lanes(Lanes)) collect (
        .clk(clk), .reset(reset), .resValid(resValid), .resWrite(resWrite),
        .resData(resData), .resMemRead(resMemRead), .resMemWrite(resMemWrite),
        .resAddr(resAddr), .resTaken(resTaken), .resTarget(resTarget),
        .resIllegal(resIllegal), .outStrobe(outStrobe), .wbEnable(wbEnable),
        .wbData(wbData), .memReadEn(memReadEn), .memWriteEn(memWriteEn),
        .memAddr(memAddr), .redirect(redirect), .redirectPc(redirectPc),
        .illegalMask(illegalMask)
    );

endmodule

// File: hw/execLane.sv
module execLane (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          laneValid,
    input  logic [execPkg::InstWidth-1:0] inst,
    input  logic [execPkg::XLen-1:0]      rs1,
    input  logic [execPkg::XLen-1:0]      rs2,
    input  logic [execPkg::XLen-1:0]      pc,
    output logic                          resValid,
    output logic                          resWrite,
    output logic [execPkg::XLen-1:0]      resData,
    output logic                          resMemRead,
    output logic                          resMemWrite,
    output logic [execPkg::XLen-1:0]      resAddr,
    output logic                          resTaken,
    output logic [execPkg::XLen-1:0]      resTarget,
    output logic                          resIllegal
);

    logic [execPkg::AluOpWidth-1:0]  aluOp;
    logic [execPkg::BruOpWidth-1:0]  bruOp;
    logic [execPkg::ImmFmtWidth-1:0] immFmt;
    logic aluSrc, memRead, memWrite, regWrite, memToReg, branch;
    logic pcOperand, zeroOperand, illegal;
    logic [execPkg::XLen-1:0] imm, opA, opB, aluRes, wbValue, target;
    logic [4:0] shamt;
    logic       condMet, taken, isJump;

    instDecode decoder (
        .inst(inst), .aluOp(aluOp), .bruOp(bruOp), .aluSrc(aluSrc),
        .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
        .memToReg(memToReg), .branch(branch), .immFmt(immFmt),
        .pcOperand(pcOperand), .zeroOperand(zeroOperand), .illegal(illegal)
    );

    always_comb begin
        unique case (immFmt)
            execPkg::ImmS: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            execPkg::ImmB: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            execPkg::ImmU: imm = {inst[31:12], 12'b0};
            execPkg::ImmJ: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
                                  1'b0};
            default:       imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    // lui adds to zero, auipc and jal add to pc
    assign opA   = zeroOperand ? '0 : (pcOperand ? pc : rs1);
    assign opB   = aluSrc ? imm : rs2;
    assign shamt = opB[4:0];

    always_comb begin
        unique case (aluOp)
            execPkg::AluSub:  aluRes = opA - opB;
            execPkg::AluSll:  aluRes = opA << shamt;
            execPkg::AluSlt:  aluRes = execPkg::XLen'($signed(opA) < $signed(opB));
            execPkg::AluSltu: aluRes = execPkg::XLen'(opA < opB);
            execPkg::AluXor:  aluRes = opA ^ opB;
            execPkg::AluSrl:  aluRes = opA >> shamt;
            execPkg::AluSra:  aluRes = $signed(opA) >>> shamt;
            execPkg::AluOr:   aluRes = opA | opB;
            execPkg::AluAnd:  aluRes = opA & opB;
            default:          aluRes = opA + opB;
        endcase
    end

    always_comb begin
        unique case (bruOp)
            execPkg::BruEq:  condMet = rs1 == rs2;
            execPkg::BruNe:  condMet = rs1 != rs2;
            execPkg::BruLt:  condMet = $signed(rs1) < $signed(rs2);
            execPkg::BruGe:  condMet = $signed(rs1) >= $signed(rs2);
            execPkg::BruLtu: condMet = rs1 < rs2;
            execPkg::BruGeu: condMet = rs1 >= rs2;
            execPkg::BruJmp: condMet = 1'b1;
            default:         condMet = 1'b0;
        endcase
    end

    assign isJump  = bruOp == execPkg::BruJmp;
    assign taken   = branch & condMet;
    // jumps take the alu sum with bit 0 cleared, branches pc plus imm
    assign target  = isJump ? {aluRes[execPkg::XLen-1:1], 1'b0} : pc + imm;
    assign wbValue = isJump ? pc + execPkg::XLen'(4) : (memToReg ? '0 : aluRes);

    always_ff @(posedge clk) begin
        if (reset) begin
            resValid    <= 1'b0;
            resWrite    <= 1'b0;
            resMemRead  <= 1'b0;
            resMemWrite <= 1'b0;
            resTaken    <= 1'b0;
            resIllegal  <= 1'b0;
        end else begin
            resValid    <= laneValid;
            resWrite    <= laneValid & regWrite;
            resMemRead  <= laneValid & memRead;
            resMemWrite <= laneValid & memWrite;
            resTaken    <= laneValid & taken;
            resIllegal  <= laneValid & illegal;
        end
    end

    always_ff @(posedge clk) begin
        resData   <= regWrite ? wbValue : '0;
        resAddr   <= (memRead | memWrite) ? aluRes : '0;
        resTarget <= taken ? target : '0;
    end

endmodule

// File: hw/execPkg.sv
package execPkg;

    // datapath widths
    localparam int XLen      = 32;
    localparam int InstWidth = 32;

    // alu operations
    localparam int AluOpWidth = 4;
    localparam logic [AluOpWidth-1:0] AluAdd  = 4'd0;
    localparam logic [AluOpWidth-1:0] AluSub  = 4'd1;
    localparam logic [AluOpWidth-1:0] AluSll  = 4'd2;
    localparam logic [AluOpWidth-1:0] AluSlt  = 4'd3;
    localparam logic [AluOpWidth-1:0] AluSltu = 4'd4;
    localparam logic [AluOpWidth-1:0] AluXor  = 4'd5;
    localparam logic [AluOpWidth-1:0] AluSrl  = 4'd6;
    localparam logic [AluOpWidth-1:0] AluSra  = 4'd7;
    localparam logic [AluOpWidth-1:0] AluOr   = 4'd8;
    localparam logic [AluOpWidth-1:0] AluAnd  = 4'd9;

    // branch unit operations
    localparam int BruOpWidth = 3;
    localparam logic [BruOpWidth-1:0] BruNop = 3'd0;
    localparam logic [BruOpWidth-1:0] BruEq  = 3'd1;
    localparam logic [BruOpWidth-1:0] BruNe  = 3'd2;
    localparam logic [BruOpWidth-1:0] BruLt  = 3'd3;
    localparam logic [BruOpWidth-1:0] BruGe  = 3'd4;
    localparam logic [BruOpWidth-1:0] BruLtu = 3'd5;
    localparam logic [BruOpWidth-1:0] BruGeu = 3'd6;
    localparam logic [BruOpWidth-1:0] BruJmp = 3'd7; // jal and jalr, always taken

    // rv32i major opcodes
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;

    // funct3, arithmetic group
    localparam logic [2:0] Funct3Add  = 3'b000;
    localparam logic [2:0] Funct3Sll  = 3'b001;
    localparam logic [2:0] Funct3Slt  = 3'b010;
    localparam logic [2:0] Funct3Sltu = 3'b011;
    localparam logic [2:0] Funct3Xor  = 3'b100;
    localparam logic [2:0] Funct3Srl  = 3'b101; // sra shares it, told apart by bit 30
    localparam logic [2:0] Funct3Or   = 3'b110;
    localparam logic [2:0] Funct3And  = 3'b111;

    // funct3, branch group
    localparam logic [2:0] Funct3Beq  = 3'b000;
    localparam logic [2:0] Funct3Bne  = 3'b001;
    localparam logic [2:0] Funct3Blt  = 3'b100;
    localparam logic [2:0] Funct3Bge  = 3'b101;
    localparam logic [2:0] Funct3Bltu = 3'b110;
    localparam logic [2:0] Funct3Bgeu = 3'b111;

    // immediate formats
    localparam int ImmFmtWidth = 3;
    localparam logic [ImmFmtWidth-1:0] ImmI = 3'd0;
    localparam logic [ImmFmtWidth-1:0] ImmS = 3'd1;
    localparam logic [ImmFmtWidth-1:0] ImmB = 3'd2;
    localparam logic [ImmFmtWidth-1:0] ImmU = 3'd3;
    localparam logic [ImmFmtWidth-1:0] ImmJ = 3'd4;

endpackage

// File: hw/instDecode.sv
module instDecode (
    input  logic [execPkg::InstWidth-1:0]   inst,
    output logic [execPkg::AluOpWidth-1:0]  aluOp,
    output logic [execPkg::BruOpWidth-1:0]  bruOp,
    output logic                            aluSrc,   // 1: imm, 0: rs2
    output logic                            memRead,
    output logic                            memWrite,
    output logic                            regWrite,
    output logic                            memToReg, // load result goes to the register
    output logic                            branch,
    output logic [execPkg::ImmFmtWidth-1:0] immFmt,
    output logic                            pcOperand,
    output logic                            zeroOperand,
    output logic                            illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;    // funct7 bit 30

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    // shared by reg and imm forms
    function automatic logic [execPkg::AluOpWidth-1:0] arithOp(
        input logic [2:0] f3,
        input logic       subSel,
        input logic       sraSel
    );
        unique case (f3)
            execPkg::Funct3Add:  arithOp = subSel ? execPkg::AluSub : execPkg::AluAdd;
            execPkg::Funct3Sll:  arithOp = execPkg::AluSll;
            execPkg::Funct3Slt:  arithOp = execPkg::AluSlt;
            execPkg::Funct3Sltu: arithOp = execPkg::AluSltu;
            execPkg::Funct3Xor:  arithOp = execPkg::AluXor;
            execPkg::Funct3Srl:  arithOp = sraSel ? execPkg::AluSra : execPkg::AluSrl;
            execPkg::Funct3Or:   arithOp = execPkg::AluOr;
            default:             arithOp = execPkg::AluAnd;
        endcase
    endfunction

    always_comb begin
        aluOp       = execPkg::AluAdd;
        bruOp       = execPkg::BruNop;
        aluSrc      = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        regWrite    = 1'b0;
        memToReg    = 1'b0;
        branch      = 1'b0;
        immFmt      = execPkg::ImmI;
        pcOperand   = 1'b0;
        zeroOperand = 1'b0;
        illegal     = 1'b0;
        unique case (opcode)
            execPkg::OpReg: begin
                aluOp    = arithOp(funct3, alt, alt);
                regWrite = 1'b1;
            end
            execPkg::OpImm: begin
                aluOp    = arithOp(funct3, 1'b0, alt); // addi never subtracts
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            execPkg::OpLoad: begin
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
                memToReg = 1'b1;
            end
            execPkg::OpStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immFmt   = execPkg::ImmS;
            end
            execPkg::OpBranch: begin
                unique case (funct3)
                    execPkg::Funct3Beq:  bruOp = execPkg::BruEq;
                    execPkg::Funct3Bne:  bruOp = execPkg::BruNe;
                    execPkg::Funct3Blt:  bruOp = execPkg::BruLt;
                    execPkg::Funct3Bge:  bruOp = execPkg::BruGe;
                    execPkg::Funct3Bltu: bruOp = execPkg::BruLtu;
                    execPkg::Funct3Bgeu: bruOp = execPkg::BruGeu;
                    default:             bruOp = execPkg::BruNop; // never taken
                endcase
                branch = 1'b1;
                immFmt = execPkg::ImmB;
            end
            execPkg::OpJalr: begin
                bruOp    = execPkg::BruJmp;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                branch   = 1'b1;
            end
            execPkg::OpJal: begin
                bruOp     = execPkg::BruJmp;
                aluSrc    = 1'b1;
                regWrite  = 1'b1;
                branch    = 1'b1;
                immFmt    = execPkg::ImmJ;
                pcOperand = 1'b1;
            end
            execPkg::OpLui: begin
                aluSrc      = 1'b1;
                regWrite    = 1'b1;
                immFmt      = execPkg::ImmU;
                zeroOperand = 1'b1;
            end
            execPkg::OpAuipc: begin
                aluSrc    = 1'b1;
                regWrite  = 1'b1;
                immFmt    = execPkg::ImmU;
                pcOperand = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: hw/resultCollect.sv
module resultCollect #(
    parameter int Lanes = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [Lanes-1:0]               resValid,
    input  logic [Lanes-1:0]               resWrite,
    input  logic [Lanes*execPkg::XLen-1:0] resData,
    input  logic [Lanes-1:0]               resMemRead,
    input  logic [Lanes-1:0]               resMemWrite,
    input  logic [Lanes*execPkg::XLen-1:0] resAddr,
    input  logic [Lanes-1:0]               resTaken,
    input  logic [Lanes*execPkg::XLen-1:0] resTarget,
    input  logic [Lanes-1:0]               resIllegal,
    output logic                           outStrobe,
    output logic [Lanes-1:0]               wbEnable,
    output logic [Lanes*execPkg::XLen-1:0] wbData,
    output logic [Lanes-1:0]               memReadEn,
    output logic [Lanes-1:0]               memWriteEn,
    output logic [Lanes*execPkg::XLen-1:0] memAddr,
    output logic                           redirect,
    output logic [execPkg::XLen-1:0]       redirectPc,
    output logic [Lanes-1:0]               illegalMask
);

    logic                     found;
    logic [Lanes-1:0]         keep;  // lanes at or before the oldest transfer
    logic [Lanes-1:0]         wbKeep, memKeep;
    logic [execPkg::XLen-1:0] takenPc;

    // lowest index wins
    always_comb begin
        found   = 1'b0;
        keep    = '1;
        takenPc = '0;
        for (int i = 0; i < Lanes; i++) begin
            if (found) begin
                keep[i] = 1'b0;
            end else if (resTaken[i]) begin
                found   = 1'b1;
                takenPc = resTarget[i*execPkg::XLen +: execPkg::XLen];
            end
        end
    end

    assign wbKeep  = resWrite & keep;
    assign memKeep = (resMemRead | resMemWrite) & keep;

    always_ff @(posedge clk) begin
        if (reset) begin
            outStrobe   <= 1'b0;
            wbEnable    <= '0;
            memReadEn   <= '0;
            memWriteEn  <= '0;
            illegalMask <= '0;
            redirect    <= 1'b0;
        end else begin
            outStrobe   <= |resValid;
            wbEnable    <= wbKeep;
            memReadEn   <= resMemRead & keep;
            memWriteEn  <= resMemWrite & keep;
            illegalMask <= resIllegal & keep;
            redirect    <= found;
        end
    end

    always_ff @(posedge clk) begin
        redirectPc <= takenPc;
        for (int i = 0; i < Lanes; i++) begin
            wbData[i*execPkg::XLen +: execPkg::XLen] <=
                wbKeep[i] ? resData[i*execPkg::XLen +: execPkg::XLen] : '0;
            memAddr[i*execPkg::XLen +: execPkg::XLen] <=
                memKeep[i] ? resAddr[i*execPkg::XLen +: execPkg::XLen] : '0;
        end
    end

endmodule

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f execCluster.f --top-module execClusterTb -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

// File: sim/execRef.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

typedef struct {
    int               testId;
    int               latchCycle;
    logic [Lanes-1:0] wbEn, rdEn, wrEn, ill;
    logic [Lanes*32-1:0] wbData, memAddr;
    logic             redirect;
    logic [31:0]      redirectPc;
} bundleExp;

function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
endfunction

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) r = $signed(a) >>> b[4:0];
            else r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// expected outputs of one bundle, younger lanes squashed behind the first transfer
function automatic bundleExp bundleRef(input logic [Lanes-1:0] mask,
        input logic [Lanes*32-1:0] ins, input logic [Lanes*32-1:0] a,
        input logic [Lanes*32-1:0] b, input logic [31:0] basePc);
    bundleExp e;
    logic [31:0] i, r1, r2, pc, iI, iS, iB, iU, iJ, data, addr, tgt;
    logic wr, rd, st, tk, il, cond, squash;
    e.wbEn = '0; e.rdEn = '0; e.wrEn = '0; e.ill = '0;
    e.wbData = '0; e.memAddr = '0; e.redirect = 1'b0; e.redirectPc = '0;
    squash = 1'b0;
    for (int n = 0; n < Lanes; n++) begin
        i = ins[n*32 +: 32]; r1 = a[n*32 +: 32]; r2 = b[n*32 +: 32];
        pc = basePc + 32'(4 * n);
        iI = {{20{i[31]}}, i[31:20]};
        iS = {{20{i[31]}}, i[31:25], i[11:7]};
        iB = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        iU = {i[31:12], 12'b0};
        iJ = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        {wr, rd, st, tk, il} = 5'b0;
        data = '0; addr = '0; tgt = '0;
        case (i[6:0])
            execPkg::OpReg: begin wr = 1; data = aluRef(i[14:12], i[30], r1, r2); end
            execPkg::OpImm: begin
                wr = 1;
                data = aluRef(i[14:12], i[14:12] == 3'd5 && i[30], r1, iI);
            end
            execPkg::OpLoad: begin wr = 1; rd = 1; addr = r1 + iI; end
            execPkg::OpStore: begin st = 1; addr = r1 + iS; end
            execPkg::OpBranch: begin
                case (i[14:12])
                    3'd0: cond = r1 == r2;
                    3'd1: cond = r1 != r2;
                    3'd4: cond = $signed(r1) < $signed(r2);
                    3'd5: cond = $signed(r1) >= $signed(r2);
                    3'd6: cond = r1 < r2;
                    3'd7: cond = r1 >= r2;
                    default: cond = 1'b0;
                endcase
                tk = cond; tgt = pc + iB;
            end
            execPkg::OpJal: begin wr = 1; data = pc + 4; tk = 1; tgt = pc + iJ; end
            execPkg::OpJalr: begin wr = 1; data = pc + 4; tk = 1; tgt = (r1 + iI) & ~32'd1; end
            execPkg::OpLui: begin wr = 1; data = iU; end
            execPkg::OpAuipc: begin wr = 1; data = pc + iU; end
            default: il = 1;
        endcase
        if (mask[n] && !squash) begin
            e.wbEn[n] = wr; e.rdEn[n] = rd; e.wrEn[n] = st; e.ill[n] = il;
            if (wr) e.wbData[n*32 +: 32] = data;
            if (rd || st) e.memAddr[n*32 +: 32] = addr;
            if (tk) begin
                e.redirect = 1'b1; e.redirectPc = tgt; squash = 1'b1;
            end
        end
    end
    return e;
endfunction

`endif

// File: sim/execClusterTb.sv
module execClusterTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int Lanes = 4;
    localparam int NumTests = 6;
    localparam int TestBundles = 8;
    localparam int StreamBundles = 24;
    localparam int TotalBundles = 5 * TestBundles + StreamBundles;
    localparam int CycleLimit = TotalBundles * 2 + 50;

    logic clk, reset, inStrobe;
    logic [Lanes-1:0] laneMask;
    logic [Lanes*32-1:0] insts, rs1Vals, rs2Vals;
    logic [31:0] basePc;
    logic outStrobe, redirect;
    logic [Lanes-1:0] wbEnable, memReadEn, memWriteEn, illegalMask;
    logic [Lanes*32-1:0] wbData, memAddr;
    logic [31:0] redirectPc;

    logic [31:0] lcgState = 32'd9;

    `include "execRef.svh"

    bundleExp expQ[$];
    int errors[NumTests];
    int strayErrors = 0;
    int checks = 0;
    int cycle = 0;
    string testNames[NumTests] = '{"arith", "luiAuipcIllegal", "loadStore", "branch",
                                   "jump", "stream"};

    execCluster #(.Lanes(Lanes)) uut (
        .clk(clk), .reset(reset), .inStrobe(inStrobe), .laneMask(laneMask),
        .insts(insts), .rs1Vals(rs1Vals), .rs2Vals(rs2Vals), .basePc(basePc),
        .outStrobe(outStrobe), .wbEnable(wbEnable), .wbData(wbData),
        .memReadEn(memReadEn), .memWriteEn(memWriteEn), .memAddr(memAddr),
        .redirect(redirect), .redirectPc(redirectPc), .illegalMask(illegalMask)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CycleLimit) begin
            $display("run stopped after %0d cycles, outputs never drained", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic mismatch(input int id, input string field, input logic [127:0] exp,
                            input logic [127:0] act);
        $display("** Error %s: %s expected %h actual %h", testNames[id], field, exp, act);
        errors[id]++;
    endtask

    always @(negedge clk) begin : compare
        bundleExp e;
        if (!reset && outStrobe) begin
            if (expQ.size() == 0) begin
                $display("outStrobe came with no bundle outstanding");
                strayErrors++;
            end else begin
                e = expQ.pop_front();
                checks++;
                if (cycle != e.latchCycle + 2) mismatch(e.testId, "latency cycle",
                    128'(e.latchCycle + 2), 128'(cycle));
                if (wbEnable != e.wbEn) mismatch(e.testId, "wbEnable", 128'(e.wbEn),
                    128'(wbEnable));
                if (wbData != e.wbData) mismatch(e.testId, "wbData", e.wbData, wbData);
                if (memReadEn != e.rdEn) mismatch(e.testId, "memReadEn", 128'(e.rdEn),
                    128'(memReadEn));
                if (memWriteEn != e.wrEn) mismatch(e.testId, "memWriteEn", 128'(e.wrEn),
                    128'(memWriteEn));
                if (memAddr != e.memAddr) mismatch(e.testId, "memAddr", e.memAddr, memAddr);
                if (redirect != e.redirect) mismatch(e.testId, "redirect", 128'(e.redirect),
                    128'(redirect));
                if (redirectPc != e.redirectPc) mismatch(e.testId, "redirectPc",
                    128'(e.redirectPc), 128'(redirectPc));
                if (illegalMask != e.ill) mismatch(e.testId, "illegalMask", 128'(e.ill),
                    128'(illegalMask));
            end
        end
    end

    // kind 0 reg, 1 imm, 2 lui, 3 auipc, 4 illegal, 5 load, 6 store, 7 branch, 8 jal, 9 jalr
    function automatic logic [31:0] genInst(input int kind);
        logic [31:0] r;
        logic [2:0] f3;
        logic [2:0] brF3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        r = nextRand();
        f3 = 3'(nextRand() >> 24);
        case (kind)
            0: return {1'b0, r[30], 5'b0, r[24:15], f3, r[11:7], execPkg::OpReg};
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    return {1'b0, r[30], 5'b0, r[24:15], f3, r[11:7], execPkg::OpImm};
                return {r[31:15], f3, r[11:7], execPkg::OpImm};
            end
            2: return {r[31:7], execPkg::OpLui};
            3: return {r[31:7], execPkg::OpAuipc};
            4: return {r[31:7], r[31] ? 7'b0001011 : 7'b1111111};
            5: return {r[31:15], 3'b010, r[11:7], execPkg::OpLoad};
            6: return {r[31:15], 3'b010, r[11:7], execPkg::OpStore};
            7: return {r[31:15], brF3[(nextRand() >> 20) % 6], r[11:7], execPkg::OpBranch};
            8: return {r[31:7], execPkg::OpJal};
            default: return {r[31:15], 3'b000, r[11:7], execPkg::OpJalr};
        endcase
    endfunction

    function automatic int pickKind(input int testId);
        int c;
        c = int'(nextRand() >> 20);
        case (testId)
            0: return c % 2;
            1: return 2 + c % 3;
            2: return 5 + c % 2;
            3: return (c % 2 == 1) ? 7 : 0;
            4: return (c % 3 != 0) ? 8 + (c >> 4) % 2 : 0;
            default: return c % 10;
        endcase
    endfunction

    task automatic runTest(input int testId, input int count);
        logic [Lanes*32-1:0] ins, a, b;
        logic [Lanes-1:0] mask;
        logic [31:0] pc, r1;
        int kind, sel;
        bundleExp e;
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            for (int l = 0; l < Lanes; l++) begin
                kind = pickKind(testId);
                r1 = nextRand();
                sel = int'(nextRand() >> 20) % 3;
                ins[l*32 +: 32] = genInst(kind);
                a[l*32 +: 32] = r1;
                // equal or sign-flipped operands give both branch outcomes
                b[l*32 +: 32] = (kind == 7 && sel == 0) ? r1 :
                                (kind == 7 && sel == 1) ? r1 ^ 32'h8000_0000 : nextRand();
            end
            pc = nextRand() & ~32'd3;
            mask = testId == 5 ? Lanes'(nextRand() >> 16) : '1;
            if (mask == '0) mask = Lanes'(1);
            insts = ins;
            rs1Vals = a;
            rs2Vals = b;
            basePc = pc;
            laneMask = mask;
            inStrobe = 1'b1;
            e = bundleRef(mask, ins, a, b, pc);
            e.testId = testId;
            e.latchCycle = cycle + 1;
            expQ.push_back(e);
        end
        @(negedge clk);
        inStrobe = 1'b0;
        laneMask = '0;
        while (expQ.size() != 0) @(negedge clk);
        if (errors[testId] == 0) $display("test %s: ok, %0d bundles", testNames[testId], count);
        else $display("test %s: %0d errors", testNames[testId], errors[testId]);
    endtask

    initial begin
        int total;
        reset = 1'b1;
        inStrobe = 1'b0;
        laneMask = '0;
        insts = '0;
        rs1Vals = '0;
        rs2Vals = '0;
        basePc = '0;
        for (int t = 0; t < NumTests; t++) errors[t] = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < NumTests - 1; t++) runTest(t, TestBundles);
        runTest(NumTests - 1, StreamBundles);
        repeat (3) @(negedge clk);
        if (expQ.size() != 0) begin
            $display("%0d expected bundles never came out", expQ.size());
            strayErrors++;
        end
        total = strayErrors;
        for (int t = 0; t < NumTests; t++) total += errors[t];
        $display("tests %0d, bundles checked %0d, errors %0d", NumTests, checks, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
